// ==== hw/rob_branch_check.sv ====
// branch misprediction check; only the gate state is registered
// a resolve of a non-branch entry is ignored
module rob_branch_check (
	input  logic              clk,
	input  logic              rst,
	input  rob_pkg::resolve_t resolve_i,
	input  rob_pkg::entry_t   entry_i,
	output logic              br_correct_o,
	output rob_pkg::recover_t recover_o,
	output logic              rollback_o,
	output rob_pkg::rob_idx_t rollback_idx_o,
	output logic              recover_busy_o
);
	import rob_pkg::*;

	recov_state_t state_r;
	logic         br_resolve;
	logic         mispredict;
	logic         recover_fire;

	//----------------------------------------------------------------------
	// compare against the stored prediction
	//----------------------------------------------------------------------
	assign br_resolve = resolve_i.valid && entry_i.pkt.is_branch;
	assign mispredict = (resolve_i.taken != entry_i.pkt.pred_taken) ||
	                    (resolve_i.target != entry_i.pkt.pred_target);

	assign br_correct_o = br_resolve && !mispredict;

	// a mispredict only counts while the gate is armed
	assign recover_fire = br_resolve && mispredict && (state_r == ARMED);

	always_comb begin
		recover_o.valid   = recover_fire;
		recover_o.fl_head = entry_i.pkt.fl_head;   // free list rewinds to here
		recover_o.br_mask = entry_i.pkt.br_mask;
	end

	assign rollback_o     = recover_fire;
	assign rollback_idx_o = resolve_i.idx;
	assign recover_busy_o = recover_fire;          // holds off dispatch

	//----------------------------------------------------------------------
	// recovery gate blocked for one cycle after each recovery
	//----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			state_r <= ARMED;
		end else begin
			case (state_r)
				ARMED:   if (recover_fire) state_r <= BLOCKED;
				BLOCKED: state_r <= ARMED;
				default: state_r <= ARMED;
			endcase
		end
	end

endmodule

// ==== hw/rob_entry_store.sv ====
// entry array of the ROB with one write per edge at the tail and combinational reads
// completion and resolve indices are assumed to name live entries
module rob_entry_store (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   dispatch_fire_i,
	input  rob_pkg::dispatch_pkt_t dispatch_pkt_i,
	input  rob_pkg::rob_idx_t      tail_idx_i,
	input  rob_pkg::rob_idx_t      head_idx_i,
	input  logic                   retire_fire_i,
	input  rob_pkg::complete_t     complete_i,
	input  rob_pkg::rob_idx_t      resolve_idx_i,
	input  rob_pkg::rob_idx_t      npc_idx_i,
	output logic                   head_done_o,
	output rob_pkg::retire_t       retire_o,
	output rob_pkg::entry_t        resolve_entry_o,
	output rob_pkg::addr_t         npc_o
);
	import rob_pkg::*;

	//----------------------------------------------------------------------
	// storage
	//----------------------------------------------------------------------
	// payload lives in a plain array, done bits in a separate vector
	// so that they can be cleared together
	dispatch_pkt_t        pkt_mem [ROB_DEPTH];
	logic [ROB_DEPTH-1:0] done_r;

	dispatch_pkt_t head_pkt;
	dispatch_pkt_t resolve_pkt;
	dispatch_pkt_t npc_pkt;

	// payload write at the tail
	always_ff @(posedge clk) begin
		if (dispatch_fire_i)
			pkt_mem[tail_idx_i] <= dispatch_pkt_i;
	end

	// done bits
	// a fresh entry and a retired head both start over as not done;
	// completion is applied last and only ever targets a live entry
	always_ff @(posedge clk) begin
		if (rst) begin
			done_r <= '0;
		end else begin
			if (retire_fire_i)
				done_r[head_idx_i] <= 1'b0;
			if (dispatch_fire_i)
				done_r[tail_idx_i] <= 1'b0;
			if (complete_i.valid)
				done_r[complete_i.idx] <= 1'b1;
		end
	end

	//----------------------------------------------------------------------
	// read ports
	//----------------------------------------------------------------------
	assign head_pkt    = pkt_mem[head_idx_i];
	assign resolve_pkt = pkt_mem[resolve_idx_i];
	assign npc_pkt     = pkt_mem[npc_idx_i];

	assign head_done_o = done_r[head_idx_i];

	// retirement record stays zero when nothing retires
	always_comb begin
		retire_o = '0;
		if (retire_fire_i) begin
			retire_o.valid    = 1'b1;
			retire_o.areg     = head_pkt.areg;       // to the arch map
			retire_o.new_preg = head_pkt.new_preg;   // to the arch map
			retire_o.old_preg = head_pkt.old_preg;   // back to the free list
			retire_o.pc       = head_pkt.pc;
		end
	end

	// entry seen by the branch checker
	always_comb begin
		resolve_entry_o.pkt  = resolve_pkt;
		resolve_entry_o.done = done_r[resolve_idx_i];
	end

	// fall-through pc for the branch unit
	assign npc_o = npc_pkt.pc + INSTR_BYTES;

endmodule

// ==== hw/rob_pkg.sv ====
// shared widths, index types and packed records of the reorder buffer
// depth must stay a power of two so the pointer wrap bit works
package rob_pkg;

	//----------------------------------------------------------------------
	// sizes
	//----------------------------------------------------------------------
	localparam int ROB_DEPTH = 32;
	localparam int ROB_IDX_W = $clog2(ROB_DEPTH);
	localparam int PREG_W    = 6;
	localparam int AREG_W    = 5;
	localparam int FL_HEAD_W = 5;
	localparam int ADDR_W    = 64;
	localparam int BR_MASK_W = 4;

	typedef logic [ROB_IDX_W-1:0] rob_idx_t;
	typedef logic [ROB_IDX_W:0]   rob_ptr_t;   // msb is the wrap bit
	typedef logic [PREG_W-1:0]    preg_t;
	typedef logic [AREG_W-1:0]    areg_t;
	typedef logic [FL_HEAD_W-1:0] fl_head_t;
	typedef logic [ADDR_W-1:0]    addr_t;
	typedef logic [BR_MASK_W-1:0] br_mask_t;

	localparam addr_t INSTR_BYTES = 64'd4;   // fixed instruction size for npc

	// gate that lets only one recovery through back to back
	typedef enum logic {
		ARMED,
		BLOCKED
	} recov_state_t;

	//----------------------------------------------------------------------
	// records
	//----------------------------------------------------------------------
	typedef struct packed {
		preg_t    old_preg;     // previous mapping of areg that retire frees
		preg_t    new_preg;     // mapping written to the arch map at retire
		areg_t    areg;
		addr_t    pc;
		logic     is_branch;
		logic     pred_taken;
		addr_t    pred_target;
		br_mask_t br_mask;
		fl_head_t fl_head;      // free list head at dispatch for recovery
	} dispatch_pkt_t;

	typedef struct packed {
		logic     valid;
		rob_idx_t idx;
		logic     taken;
	} complete_t;

	typedef struct packed {
		logic     valid;
		rob_idx_t idx;
		logic     taken;
		addr_t    target;
	} resolve_t;

	typedef struct packed {
		logic  valid;
		areg_t areg;
		preg_t new_preg;
		preg_t old_preg;
		addr_t pc;
	} retire_t;

	typedef struct packed {
		logic     valid;
		fl_head_t fl_head;
		br_mask_t br_mask;
	} recover_t;

	typedef struct packed {
		dispatch_pkt_t pkt;
		logic          done;
	} entry_t;

endpackage

// ==== hw/rob_ptr_ctrl.sv ====
// head/tail pointers of the ROB; rollback beats a dispatch in the same cycle
// rollback index must name a live entry, otherwise the wrap bit is wrong
module rob_ptr_ctrl (
	input  logic              clk,
	input  logic              rst,
	input  logic              dispatch_valid_i,
	input  logic              head_done_i,
	input  logic              rollback_i,
	input  rob_pkg::rob_idx_t rollback_idx_i,
	input  logic              recover_busy_i,
	output rob_pkg::rob_ptr_t head_o,
	output rob_pkg::rob_ptr_t tail_o,
	output logic              dispatch_fire_o,
	output logic              retire_fire_o,
	output logic              stall_o
);
	import rob_pkg::*;

	rob_ptr_t head_r;
	rob_ptr_t tail_r;
	rob_ptr_t br_ptr;      // branch position with its wrap bit restored
	logic     empty;
	logic     full;

	//----------------------------------------------------------------------
	// occupancy
	//----------------------------------------------------------------------
	assign empty = (head_r == tail_r);
	assign full  = (head_r[ROB_IDX_W-1:0] == tail_r[ROB_IDX_W-1:0]) &&
	               (head_r[ROB_IDX_W] != tail_r[ROB_IDX_W]);

	assign retire_fire_o = head_done_i && !empty;

	// a retiring head frees one slot in the same cycle
	assign stall_o         = (full && !retire_fire_o) || recover_busy_i;
	assign dispatch_fire_o = dispatch_valid_i && !stall_o;

	// branch sits between head and tail, so its wrap bit follows the head
	// unless its index has already wrapped past zero
	always_comb begin
		br_ptr[ROB_IDX_W-1:0] = rollback_idx_i;
		if (rollback_idx_i >= head_r[ROB_IDX_W-1:0]) begin
			br_ptr[ROB_IDX_W] = head_r[ROB_IDX_W];
		end else begin
			br_ptr[ROB_IDX_W] = ~head_r[ROB_IDX_W];
		end
	end

	//----------------------------------------------------------------------
	// pointer registers
	//----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			head_r <= '0;
			tail_r <= '0;
		end else begin
			if (retire_fire_o)
				head_r <= head_r + 1'b1;
			if (rollback_i)
				tail_r <= br_ptr + 1'b1;    // drop everything younger than the branch
			else if (dispatch_fire_o)
				tail_r <= tail_r + 1'b1;
		end
	end

	assign head_o = head_r;
	assign tail_o = tail_r;

endmodule

// ==== hw/rob_top.sv ====
// 32-entry reorder buffer with one dispatch and one retirement per cycle
// sender holds dispatch_pkt_i while stall_o is high
module rob_top (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   dispatch_valid_i,
	input  rob_pkg::dispatch_pkt_t dispatch_pkt_i,
	input  rob_pkg::complete_t     complete_i,
	input  rob_pkg::resolve_t      resolve_i,
	input  rob_pkg::rob_idx_t      npc_idx_i,
	output logic                   stall_o,
	output rob_pkg::rob_idx_t      tail_idx_o,
	output rob_pkg::addr_t         npc_o,
	output rob_pkg::retire_t       retire_o,
	output rob_pkg::recover_t      recover_o,
	output logic                   br_correct_o
);
	import rob_pkg::*;

	rob_ptr_t head_ptr;
	rob_ptr_t tail_ptr;
	logic     dispatch_fire;
	logic     retire_fire;
	logic     head_done;
	logic     rollback;
	rob_idx_t rollback_idx;
	logic     recover_busy;
	entry_t   resolve_entry;

	assign tail_idx_o = tail_ptr[ROB_IDX_W-1:0];   // slot of the next dispatch

	//----------------------------------------------------------------------
	// blocks
	//----------------------------------------------------------------------
	rob_ptr_ctrl i_rob_ptr_ctrl (
		.clk              (clk),
		.rst              (rst),
		.dispatch_valid_i (dispatch_valid_i),
		.head_done_i      (head_done),
		.rollback_i       (rollback),
		.rollback_idx_i   (rollback_idx),
		.recover_busy_i   (recover_busy),
		.head_o           (head_ptr),
		.tail_o           (tail_ptr),
		.dispatch_fire_o  (dispatch_fire),
		.retire_fire_o    (retire_fire),
		.stall_o          (stall_o)
	);

	rob_entry_store i_rob_entry_store (
		.clk             (clk),
		.rst             (rst),
		.dispatch_fire_i (dispatch_fire),
		.dispatch_pkt_i  (dispatch_pkt_i),
		.tail_idx_i      (tail_ptr[ROB_IDX_W-1:0]),
		.head_idx_i      (head_ptr[ROB_IDX_W-1:0]),
		.retire_fire_i   (retire_fire),
		.complete_i      (complete_i),
		.resolve_idx_i   (resolve_i.idx),
		.npc_idx_i       (npc_idx_i),
		.head_done_o     (head_done),
		.retire_o        (retire_o),
		.resolve_entry_o (resolve_entry),
		.npc_o           (npc_o)
	);

	rob_branch_check i_rob_branch_check (
		.clk            (clk),
		.rst            (rst),
		.resolve_i      (resolve_i),
		.entry_i        (resolve_entry),
		.br_correct_o   (br_correct_o),
		.recover_o      (recover_o),
		.rollback_o     (rollback),
		.rollback_idx_o (rollback_idx),
		.recover_busy_o (recover_busy)
	);

endmodule

// ==== project.f ====
hw/rob_pkg.sv
hw/rob_ptr_ctrl.sv
hw/rob_entry_store.sv
hw/rob_branch_check.sv
hw/rob_top.sv
verif/rob_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the ROB testbench with Verilator and runs it
# exit status is zero only when the pass line shows up in the output
cd "$(dirname "$0")" &&
verilator --binary --timing -f project.f --top-module rob_tb -o rob_tb_sim &&
./obj_dir/rob_tb_sim | tee /dev/stderr | grep -q -x "=== PASS ===" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== verif/rob_tb.sv ====
// testbench for rob_top with random packets from a fixed $urandom seed
// completions and branch resolves only ever name live entries
module rob_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import rob_pkg::*;

	localparam int          CLK_HALF     = 20;
	localparam int          RESET_CYCLES = 16;
	localparam int          WAIT_LIMIT   = 200;   // cycles any single wait may take
	localparam logic [31:0] SEED         = 32'hd636_1d90;

	typedef struct packed {
		rob_idx_t      idx;
		dispatch_pkt_t pkt;
	} slot_t;

	logic          clk = 1'b0;
	logic          rst;
	logic          dispatch_valid_i;
	dispatch_pkt_t dispatch_pkt_i;
	complete_t     complete_i;
	resolve_t      resolve_i;
	rob_idx_t      npc_idx_i;
	logic          stall_o;
	rob_idx_t      tail_idx_o;
	addr_t         npc_o;
	retire_t       retire_o;
	recover_t      recover_o;
	logic          br_correct_o;

	slot_t    model_q[$];            // live entries, oldest first
	rob_idx_t exp_tail;              // slot the next dispatch should get
	string    cur_test;
	int       check_errs    = 0;
	int       retire_errs   = 0;     // owned by the retire checker
	int       retire_count  = 0;
	int       errs_at_start = 0;
	int       tests_passed  = 0;
	int       tests_failed  = 0;

	always #CLK_HALF clk = ~clk;

	rob_top i_rob_top (
		.clk              (clk),
		.rst              (rst),
		.dispatch_valid_i (dispatch_valid_i),
		.dispatch_pkt_i   (dispatch_pkt_i),
		.complete_i       (complete_i),
		.resolve_i        (resolve_i),
		.npc_idx_i        (npc_idx_i),
		.stall_o          (stall_o),
		.tail_idx_o       (tail_idx_o),
		.npc_o            (npc_o),
		.retire_o         (retire_o),
		.recover_o        (recover_o),
		.br_correct_o     (br_correct_o)
	);

	//----------------------------------------------------------------------
	// reference model
	//----------------------------------------------------------------------
	// head entry goes out with its tags, areg and pc
	function automatic retire_t retire_record(input dispatch_pkt_t p);
		retire_t r;
		r.valid    = 1'b1;
		r.areg     = p.areg;
		r.new_preg = p.new_preg;
		r.old_preg = p.old_preg;
		r.pc       = p.pc;
		return r;
	endfunction

	function automatic addr_t next_pc(input addr_t pc);
		return pc + 64'd4;
	endfunction

	// a mispredict hands back the state saved at dispatch
	function automatic recover_t recover_record(input dispatch_pkt_t p);
		recover_t r;
		r.valid   = 1'b1;
		r.fl_head = p.fl_head;
		r.br_mask = p.br_mask;
		return r;
	endfunction

	function automatic dispatch_pkt_t random_pkt(input logic branch);
		dispatch_pkt_t p;
		p.old_preg    = preg_t'($urandom);
		p.new_preg    = preg_t'($urandom);
		p.areg        = areg_t'($urandom);
		p.pc          = {$urandom, $urandom & 32'hffff_fffc};   // word aligned
		p.is_branch   = branch;
		p.pred_taken  = 1'($urandom);
		p.pred_target = {$urandom, $urandom & 32'hffff_fffc};
		p.br_mask     = br_mask_t'($urandom);
		p.fl_head     = fl_head_t'($urandom);
		return p;
	endfunction

	//----------------------------------------------------------------------
	// helpers
	//----------------------------------------------------------------------
	task automatic report_mismatch(input string what, input logic [63:0] exp_v,
	                               input logic [63:0] act_v);
		$display("FAIL %s: %s expected %0h actual %0h", cur_test, what, exp_v, act_v);
		check_errs++;
	endtask

	task automatic abort_on_timeout(input string what);
		$display("ERROR %s: timed out, %s", cur_test, what);
		$display("=== FAIL ===");
		$finish;
	endtask

	task automatic start_test(input string name);
		cur_test      = name;
		errs_at_start = check_errs + retire_errs;
	endtask

	task automatic end_test();
		int errs;
		errs = check_errs + retire_errs - errs_at_start;
		if (errs == 0) begin
			$display("test %s: ok", cur_test);
			tests_passed++;
		end else begin
			$display("test %s: %0d failed checks", cur_test, errs);
			tests_failed++;
		end
	endtask

	// holds the packet until accepted, then records it in the model
	task automatic send_dispatch(input dispatch_pkt_t p, output rob_idx_t idx);
		slot_t s;
		int    waited;
		@(posedge clk);
		dispatch_valid_i <= 1'b1;
		dispatch_pkt_i   <= p;
		waited = 0;
		@(negedge clk);
		while (stall_o) begin
			waited++;
			if (waited > WAIT_LIMIT)
				abort_on_timeout("dispatch held off by stall_o");
			@(negedge clk);
		end
		if (tail_idx_o !== exp_tail)
			report_mismatch("dispatch slot", 64'(exp_tail), 64'(tail_idx_o));
		idx = exp_tail;
		@(posedge clk);                  // accepting edge
		dispatch_valid_i <= 1'b0;
		s.idx = idx;
		s.pkt = p;
		model_q.push_back(s);
		exp_tail = exp_tail + rob_idx_t'(1);
	endtask

	task automatic mark_complete(input rob_idx_t idx);
		@(posedge clk);
		complete_i <= '{valid: 1'b1, idx: idx, taken: 1'b0};
		@(posedge clk);
		complete_i <= '0;
	endtask

	// drives one resolve pulse and samples the outputs inside it
	task automatic resolve_branch(input rob_idx_t idx, input logic taken, input addr_t target,
	                              output logic correct, output recover_t rec);
		@(posedge clk);
		resolve_i <= '{valid: 1'b1, idx: idx, taken: taken, target: target};
		@(negedge clk);
		correct = br_correct_o;
		rec     = recover_o;
		@(posedge clk);
		resolve_i <= '0;
	endtask

	task automatic wait_retires(input int target);
		int cycles;
		cycles = 0;
		while (retire_count < target) begin
			cycles++;
			if (cycles > WAIT_LIMIT)
				abort_on_timeout("retirements did not arrive");
			@(posedge clk);
		end
	endtask

	// completes every live entry in random order and waits for all of them
	task automatic drain_rob();
		rob_idx_t order[$];
		rob_idx_t tmp;
		int       target;
		int       i;
		int       j;
		@(posedge clk);
		foreach (model_q[k])
			order.push_back(model_q[k].idx);
		for (i = order.size() - 1; i > 0; i--) begin
			j        = int'($urandom_range(i, 0));
			tmp      = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		target = retire_count + order.size();
		foreach (order[k])
			mark_complete(order[k]);
		wait_retires(target);
	endtask

	//----------------------------------------------------------------------
	// retire checker
	//----------------------------------------------------------------------
	always @(negedge clk) begin
		slot_t head;
		if (!rst && retire_o.valid) begin
			if (model_q.size() == 0) begin
				$display("ERROR %s: retirement of pc %h with no live entry", cur_test,
				         retire_o.pc);
				retire_errs++;
			end else begin
				head = model_q.pop_front();
				if (retire_o !== retire_record(head.pkt)) begin
					$display("FAIL %s: retire of slot %0d expected %h actual %h", cur_test,
					         head.idx, retire_record(head.pkt), retire_o);
					retire_errs++;
				end
			end
			retire_count++;
		end
	end

	//----------------------------------------------------------------------
	// stimulus
	//----------------------------------------------------------------------
	initial begin
		int            i;
		int            accepted;
		int            cycles;
		int            base;
		rob_idx_t      idx;
		rob_idx_t      br_idx;
		rob_idx_t      freed;
		dispatch_pkt_t br_pkt;
		slot_t         pick;
		logic          correct;
		recover_t      rec;

		void'($urandom(SEED));
		rst              <= 1'b1;
		dispatch_valid_i <= 1'b0;
		dispatch_pkt_i   <= '0;
		complete_i       <= '0;
		resolve_i        <= '0;
		npc_idx_i        <= '0;
		exp_tail = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;

		start_test("reset_state");
		@(negedge clk);
		if (stall_o !== 1'b0)
			report_mismatch("stall_o", 64'd0, 64'(stall_o));
		if (retire_o.valid !== 1'b0)
			report_mismatch("retire_o.valid", 64'd0, 64'(retire_o.valid));
		if (recover_o.valid !== 1'b0)
			report_mismatch("recover_o.valid", 64'd0, 64'(recover_o.valid));
		if (br_correct_o !== 1'b0)
			report_mismatch("br_correct_o", 64'd0, 64'(br_correct_o));
		if (tail_idx_o !== '0)
			report_mismatch("tail_idx_o", 64'd0, 64'(tail_idx_o));
		end_test();

		start_test("in_order_retire");
		base = retire_count;
		for (i = 0; i < 20; i++)
			send_dispatch(random_pkt(1'b0), idx);
		drain_rob();
		repeat (8) @(posedge clk);
		if (retire_count != base + 20)
			report_mismatch("retirements", 64'(base + 20), 64'(retire_count));
		end_test();

		start_test("full_stall");
		accepted = 0;
		@(negedge clk);
		while (!stall_o && accepted < 40) begin
			send_dispatch(random_pkt(1'b0), idx);
			accepted++;
			@(negedge clk);
		end
		if (accepted != ROB_DEPTH)
			report_mismatch("packets before stall", 64'(ROB_DEPTH), 64'(accepted));
		@(posedge clk);
		freed = model_q[0].idx;          // head of a full ROB
		mark_complete(freed);
		cycles = 0;
		@(negedge clk);
		while (stall_o) begin
			cycles++;
			if (cycles > WAIT_LIMIT)
				abort_on_timeout("stall_o stayed high after the head completed");
			@(negedge clk);
		end
		send_dispatch(random_pkt(1'b0), idx);
		if (idx !== freed)
			report_mismatch("slot after head retired", 64'(freed), 64'(idx));
		@(negedge clk);
		if (stall_o !== 1'b1)
			report_mismatch("stall_o when full again", 64'd1, 64'(stall_o));
		end_test();

		// ROB is full here, so every index is live
		start_test("npc_read");
		for (i = 0; i < 8; i++) begin
			@(posedge clk);
			pick = model_q[$urandom_range(model_q.size() - 1, 0)];
			npc_idx_i <= pick.idx;
			@(negedge clk);
			if (npc_o !== next_pc(pick.pkt.pc))
				report_mismatch("npc_o", next_pc(pick.pkt.pc), npc_o);
		end
		drain_rob();
		end_test();

		start_test("branch_correct");
		send_dispatch(random_pkt(1'b0), idx);
		br_pkt = random_pkt(1'b1);
		send_dispatch(br_pkt, br_idx);
		send_dispatch(random_pkt(1'b0), idx);
		resolve_branch(br_idx, br_pkt.pred_taken, br_pkt.pred_target, correct, rec);
		if (correct !== 1'b1)
			report_mismatch("br_correct_o", 64'd1, 64'(correct));
		if (rec.valid !== 1'b0)
			report_mismatch("recover_o.valid", 64'd0, 64'(rec.valid));
		@(negedge clk);
		if (tail_idx_o !== exp_tail)
			report_mismatch("tail after correct branch", 64'(exp_tail), 64'(tail_idx_o));
		drain_rob();
		end_test();

		start_test("branch_mispredict");
		send_dispatch(random_pkt(1'b0), idx);
		br_pkt = random_pkt(1'b1);
		send_dispatch(br_pkt, br_idx);
		for (i = 0; i < 3; i++) begin
			send_dispatch(random_pkt(1'b0), idx);
			mark_complete(idx);          // done younger entries would retire without the rollback
		end
		resolve_branch(br_idx, br_pkt.pred_taken, br_pkt.pred_target ^ 64'h100, correct, rec);
		if (rec !== recover_record(br_pkt))
			report_mismatch("recover_o", 64'(recover_record(br_pkt)), 64'(rec));
		if (correct !== 1'b0)
			report_mismatch("br_correct_o", 64'd0, 64'(correct));
		// younger entries leave the model, tail restarts after the branch
		while (model_q.size() > 0 && model_q[$].idx != br_idx)
			void'(model_q.pop_back());
		exp_tail = br_idx + rob_idx_t'(1);
		@(negedge clk);
		if (tail_idx_o !== exp_tail)
			report_mismatch("tail after rollback", 64'(exp_tail), 64'(tail_idx_o));
		base = retire_count;
		drain_rob();
		repeat (8) @(posedge clk);
		if (retire_count != base + 2)
			report_mismatch("retirements up to branch", 64'(base + 2), 64'(retire_count));
		send_dispatch(random_pkt(1'b0), idx);
		drain_rob();
		end_test();

		$display("tests passed %0d, failed %0d, failed checks %0d", tests_passed,
		         tests_failed, check_errs + retire_errs);
		if (tests_failed == 0 && check_errs + retire_errs == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule
